// ==== all.f ====
common/bps_pkg.sv
rtl/bps_field_ram.sv
rtl/bps_cell_counter.sv
rtl/bps_beat_pack.sv
rtl/bps_msg_norm.sv
store/bps_store_queue.sv
rtl/bps_ctrl.sv
rtl/bps_top.sv
tb/bps_mem_model.sv
tb/bps_tb.sv

// ==== common/bps_pkg.sv ====
package bps_pkg;

    // field geometry
    localparam int FIELD_WIDTH     = 8;
    localparam int FIELD_HEIGHT    = 8;
    localparam int FIELD_CELLS     = FIELD_WIDTH * FIELD_HEIGHT;
    localparam int CELL_ADDR_WIDTH = $clog2(FIELD_CELLS);

    localparam int LABELS     = 16;
    localparam int COST_WIDTH = 8;
    localparam int MSG_WIDTH  = 6;
    localparam int MSG_MAX    = 63;

    // memory layout of the field record, in bytes
    localparam int BEAT_BYTES  = 8;
    localparam int WORD_BYTES  = 16;
    localparam int DATA_OFFSET = 40;

    localparam int QUEUE_DEPTH = 4;

    typedef logic [47:0] mc_addr_t;
    typedef logic [63:0] beat_t;
    typedef logic [COST_WIDTH-1:0] cost_t;
    typedef logic [MSG_WIDTH-1:0] msg_t;

    // label 0 sits in the low bits
    typedef msg_t [LABELS-1:0] msg_word_t;

    // a cost word or a widened message word, seen as memory beats or label lanes
    typedef union packed {
        beat_t [1:0] beats;
        cost_t [LABELS-1:0] lanes;
    } data_word_t;

    typedef enum logic [2:0] {
        OP_IDLE       = 3'd0,
        OP_LOAD       = 3'd1,
        OP_DOWN       = 3'd2,
        OP_STORE_DOWN = 3'd4
    } bps_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DOWN,
        ST_STORE
    } bps_state_t;

endpackage

// ==== rtl/bps_beat_pack.sv ====
`timescale 1ns/10ps

module bps_beat_pack import bps_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       rsp_push,
    input  beat_t                      rsp_data,
    output logic                       wr,
    output logic [CELL_ADDR_WIDTH-1:0] wr_addr,
    output data_word_t                 wr_data,
    output logic                       written
);

    // high once beat 0 of the current cell has arrived
    logic half;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            half    <= 1'b0;
            wr      <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr <= rsp_push && half;
            if (rsp_push) begin
                half <= !half;
            end
            if (wr) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_push) begin
            wr_data.beats[half] <= rsp_data;
        end
    end

    assign written = wr;

endmodule

// ==== rtl/bps_cell_counter.sv ====
`timescale 1ns/10ps

module bps_cell_counter import bps_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       step_req,
    input  logic                       step_cell,
    input  logic                       row_only,
    output logic [CELL_ADDR_WIDTH:0]   req_count,
    output logic [CELL_ADDR_WIDTH-1:0] cell_index,
    output logic                       req_last,
    output logic                       cell_last
);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            req_count  <= '0;
            cell_index <= '0;
        end else begin
            if (step_req) begin
                req_count <= req_count + 1'b1;
            end
            if (step_cell) begin
                cell_index <= cell_index + 1'b1;
            end
        end
    end

    // each cell takes two load beats
    assign req_last  = (req_count == (CELL_ADDR_WIDTH + 1)'(2 * FIELD_CELLS - 1));
    assign cell_last = row_only ? (cell_index == CELL_ADDR_WIDTH'(FIELD_WIDTH - 1))
                                : (cell_index == CELL_ADDR_WIDTH'(FIELD_CELLS - 1));

endmodule

// ==== rtl/bps_ctrl.sv ====
`timescale 1ns/10ps

module bps_ctrl import bps_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  bps_op_t                    opcode,
    input  logic [63:0]                addr_base,
    output logic                       busy,
    output logic                       mc_req_ld,
    output mc_addr_t                   ld_vadr,
    input  logic                       mc_req_stall,
    input  logic                       cost_written,
    output logic                       cnt_clear,
    output logic                       step_req,
    output logic                       step_cell,
    output logic                       row_only,
    input  logic [CELL_ADDR_WIDTH:0]   req_count,
    input  logic [CELL_ADDR_WIDTH-1:0] cell_index,
    input  logic                       req_last,
    input  logic                       cell_last,
    output logic [CELL_ADDR_WIDTH-1:0] cost_rd_addr,
    output logic [CELL_ADDR_WIDTH-1:0] msg_rd_addr,
    output logic [CELL_ADDR_WIDTH-1:0] msg_wr_addr,
    output logic                       msg_wr,
    output logic                       queue_push,
    output logic [CELL_ADDR_WIDTH-1:0] push_index,
    input  logic                       queue_full,
    input  logic                       queue_empty,
    output mc_addr_t                   store_base
);

    bps_state_t                 state;
    mc_addr_t                   base_q;
    logic                       issue_done;
    logic                       ld_issue;
    logic                       down_issue;
    logic                       store_issue;
    logic [2:0]                 down_vld;
    logic [CELL_ADDR_WIDTH-1:0] down_addr [3];

    // a new load may go out when the port is free or the current one is taken
    assign ld_issue    = (state == ST_LOAD) && !issue_done && (!mc_req_ld || !mc_req_stall);
    assign down_issue  = (state == ST_DOWN) && !issue_done;
    assign store_issue = (state == ST_STORE) && !issue_done && !queue_full;

    assign busy      = (state != ST_IDLE);
    assign cnt_clear = (state == ST_IDLE);
    assign row_only  = (state != ST_LOAD);
    assign step_req  = ld_issue;
    assign step_cell = (state == ST_LOAD) ? cost_written : (down_issue || store_issue);

    assign cost_rd_addr = cell_index;
    assign msg_rd_addr  = cell_index;
    assign store_base   = base_q + mc_addr_t'(DATA_OFFSET) + mc_addr_t'(WORD_BYTES * FIELD_CELLS);

    // the read address one cycle on is the cell whose message the queue takes
    assign push_index  = down_addr[0];
    assign msg_wr      = down_vld[2];
    assign msg_wr_addr = down_addr[2];

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            issue_done <= 1'b0;
            mc_req_ld  <= 1'b0;
            down_vld   <= '0;
            queue_push <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    issue_done <= 1'b0;
                    case (opcode)
                        OP_LOAD:       state <= ST_LOAD;
                        OP_DOWN:       state <= ST_DOWN;
                        OP_STORE_DOWN: state <= ST_STORE;
                        default:       state <= ST_IDLE;
                    endcase
                end
                ST_LOAD: begin
                    if (cost_written && cell_last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_DOWN: begin
                    if (msg_wr && msg_wr_addr == CELL_ADDR_WIDTH'(FIELD_WIDTH - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (issue_done && !queue_push && queue_empty) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
            if ((ld_issue && req_last) || ((down_issue || store_issue) && cell_last)) begin
                issue_done <= 1'b1;
            end
            if (ld_issue) begin
                mc_req_ld <= 1'b1;
            end else if (!mc_req_stall) begin
                mc_req_ld <= 1'b0;
            end
            // RAM read and two normalizer stages
            down_vld   <= {down_vld[1:0], down_issue};
            queue_push <= store_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            base_q <= addr_base[47:0];
        end
        if (ld_issue) begin
            ld_vadr <= base_q + mc_addr_t'(DATA_OFFSET)
                     + mc_addr_t'(req_count) * mc_addr_t'(BEAT_BYTES);
        end
        down_addr[0] <= cell_index;
        down_addr[1] <= down_addr[0];
        down_addr[2] <= down_addr[1];
    end

endmodule

// ==== rtl/bps_field_ram.sv ====
`timescale 1ns/10ps

module bps_field_ram #(
    parameter int WIDTH = 128,
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     wr,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/bps_msg_norm.sv ====
`timescale 1ns/10ps

module bps_msg_norm import bps_pkg::*; (
    input  logic       clk,
    input  data_word_t cost,
    output msg_word_t  msg
);

    data_word_t cost_q;
    cost_t      min_c;
    cost_t      min_q;
    msg_word_t  msg_c;

    always_comb begin
        min_c = cost.lanes[0];
        for (int l = 1; l < LABELS; l++) begin
            if (cost.lanes[l] < min_c) begin
                min_c = cost.lanes[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        cost_q <= cost;
        min_q  <= min_c;
    end

    // distance from the cheapest label, clipped to the message range
    always_comb begin
        cost_t diff;
        for (int l = 0; l < LABELS; l++) begin
            diff = cost_q.lanes[l] - min_q;
            if (diff > cost_t'(MSG_MAX)) begin
                msg_c[l] = msg_t'(MSG_MAX);
            end else begin
                msg_c[l] = diff[MSG_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        msg <= msg_c;
    end

endmodule

// ==== rtl/bps_top.sv ====
`timescale 1ns/10ps

module bps_top import bps_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bps_op_t     opcode,
    input  logic [63:0] addr_base,
    output logic        busy,
    output logic        mc_req_ld,
    output logic        mc_req_st,
    output mc_addr_t    mc_req_vadr,
    output beat_t       mc_req_wdata,
    input  logic        mc_req_stall,
    input  logic        mc_rsp_push,
    input  beat_t       mc_rsp_data
);

    logic                       cnt_clear;
    logic                       step_req;
    logic                       step_cell;
    logic                       row_only;
    logic [CELL_ADDR_WIDTH:0]   req_count;
    logic [CELL_ADDR_WIDTH-1:0] cell_index;
    logic                       req_last;
    logic                       cell_last;
    mc_addr_t                   ld_vadr;
    mc_addr_t                   st_vadr;
    mc_addr_t                   store_base;

    logic                       cost_wr;
    logic [CELL_ADDR_WIDTH-1:0] cost_wr_addr;
    data_word_t                 cost_wr_data;
    logic                       cost_written;
    logic [CELL_ADDR_WIDTH-1:0] cost_rd_addr;
    data_word_t                 cost_rd_data;

    logic                       msg_wr;
    logic [CELL_ADDR_WIDTH-1:0] msg_wr_addr;
    msg_word_t                  msg_wr_data;
    logic [CELL_ADDR_WIDTH-1:0] msg_rd_addr;
    msg_word_t                  msg_rd_data;

    logic                       queue_push;
    logic [CELL_ADDR_WIDTH-1:0] push_index;
    logic                       queue_full;
    logic                       queue_empty;

    // loads and stores never overlap, so the address port follows whichever is active
    assign mc_req_vadr = mc_req_st ? st_vadr : ld_vadr;

    bps_ctrl i_bps_ctrl (
        .clk          (clk),
        .rst          (rst),
        .opcode       (opcode),
        .addr_base    (addr_base),
        .busy         (busy),
        .mc_req_ld    (mc_req_ld),
        .ld_vadr      (ld_vadr),
        .mc_req_stall (mc_req_stall),
        .cost_written (cost_written),
        .cnt_clear    (cnt_clear),
        .step_req     (step_req),
        .step_cell    (step_cell),
        .row_only     (row_only),
        .req_count    (req_count),
        .cell_index   (cell_index),
        .req_last     (req_last),
        .cell_last    (cell_last),
        .cost_rd_addr (cost_rd_addr),
        .msg_rd_addr  (msg_rd_addr),
        .msg_wr_addr  (msg_wr_addr),
        .msg_wr       (msg_wr),
        .queue_push   (queue_push),
        .push_index   (push_index),
        .queue_full   (queue_full),
        .queue_empty  (queue_empty),
        .store_base   (store_base)
    );

    bps_cell_counter i_bps_cell_counter (
        .clk        (clk),
        .rst        (rst),
        .clear      (cnt_clear),
        .step_req   (step_req),
        .step_cell  (step_cell),
        .row_only   (row_only),
        .req_count  (req_count),
        .cell_index (cell_index),
        .req_last   (req_last),
        .cell_last  (cell_last)
    );

    bps_beat_pack i_bps_beat_pack (
        .clk      (clk),
        .rst      (rst),
        .clear    (cnt_clear),
        .rsp_push (mc_rsp_push),
        .rsp_data (mc_rsp_data),
        .wr       (cost_wr),
        .wr_addr  (cost_wr_addr),
        .wr_data  (cost_wr_data),
        .written  (cost_written)
    );

    bps_field_ram #(.WIDTH(LABELS * COST_WIDTH), .DEPTH(FIELD_CELLS)) i_cost_ram (
        .clk     (clk),
        .wr      (cost_wr),
        .wr_addr (cost_wr_addr),
        .wr_data (cost_wr_data),
        .rd_addr (cost_rd_addr),
        .rd_data (cost_rd_data)
    );

    bps_msg_norm i_bps_msg_norm (
        .clk  (clk),
        .cost (cost_rd_data),
        .msg  (msg_wr_data)
    );

    bps_field_ram #(.WIDTH(LABELS * MSG_WIDTH), .DEPTH(FIELD_CELLS)) i_msg_ram (
        .clk     (clk),
        .wr      (msg_wr),
        .wr_addr (msg_wr_addr),
        .wr_data (msg_wr_data),
        .rd_addr (msg_rd_addr),
        .rd_data (msg_rd_data)
    );

    bps_store_queue i_bps_store_queue (
        .clk          (clk),
        .rst          (rst),
        .push         (queue_push),
        .msg          (msg_rd_data),
        .cell_index   (push_index),
        .store_base   (store_base),
        .full         (queue_full),
        .empty        (queue_empty),
        .mc_req_st    (mc_req_st),
        .mc_req_vadr  (st_vadr),
        .mc_req_wdata (mc_req_wdata),
        .mc_req_stall (mc_req_stall)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module bps_tb -f all.f -o bps_sim

# the log decides the result, since the pipe hides the simulator status
./obj_dir/bps_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== store/bps_store_queue.sv ====
`timescale 1ns/10ps

module bps_store_queue import bps_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  msg_word_t                  msg,
    input  logic [CELL_ADDR_WIDTH-1:0] cell_index,
    input  mc_addr_t                   store_base,
    output logic                       full,
    output logic                       empty,
    output logic                       mc_req_st,
    output mc_addr_t                   mc_req_vadr,
    output beat_t                      mc_req_wdata,
    input  logic                       mc_req_stall
);

    data_word_t                       words [QUEUE_DEPTH];
    logic [CELL_ADDR_WIDTH-1:0]       index [QUEUE_DEPTH];
    data_word_t                       word_c;
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH):0]     count;
    logic                             beat_sel;
    logic                             accept;
    logic                             pop;

    always_comb begin
        for (int l = 0; l < LABELS; l++) begin
            word_c.lanes[l] = cost_t'(msg[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            words[wr_ptr] <= word_c;
            index[wr_ptr] <= cell_index;
        end
    end

    assign accept = mc_req_st && !mc_req_stall;
    assign pop    = accept && beat_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            beat_sel <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (accept) begin
                beat_sel <= !beat_sel;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);
    // one slot stays free for the message read that is already on its way
    assign full  = (count >= ($clog2(QUEUE_DEPTH) + 1)'(QUEUE_DEPTH - 1));

    assign mc_req_st    = !empty;
    assign mc_req_wdata = words[rd_ptr].beats[beat_sel];
    assign mc_req_vadr  = store_base + mc_addr_t'(index[rd_ptr]) * mc_addr_t'(WORD_BYTES)
                        + mc_addr_t'(beat_sel) * mc_addr_t'(BEAT_BYTES);

endmodule

// ==== tb/bps_mem_model.sv ====
`timescale 1ns/10ps

module bps_mem_model import bps_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     mc_req_ld,
    input  logic     mc_req_st,
    input  mc_addr_t mc_req_vadr,
    input  beat_t    mc_req_wdata,
    output logic     mc_req_stall,
    output logic     mc_rsp_push,
    output beat_t    mc_rsp_data
);

    integer   seed = 50359;
    beat_t    mem [mc_addr_t];
    beat_t    rsp_data_q [$];
    int       rsp_due_q [$];
    int       cycle = 0;
    int       st_count = 0;
    logic     stall_q = 1'b0;
    logic     push_q = 1'b0;
    beat_t    data_q = '0;

    assign mc_req_stall = stall_q;
    assign mc_rsp_push  = push_q;
    assign mc_rsp_data  = data_q;

    // each cell gets two beats of random costs in the cost area
    task automatic fill_costs(input mc_addr_t cost_base);
        for (int c = 0; c < FIELD_CELLS; c++) begin
            for (int b = 0; b < 2; b++) begin
                mem[cost_base + mc_addr_t'(c * WORD_BYTES + b * BEAT_BYTES)] =
                    {$random(seed), $random(seed)};
            end
        end
    endtask

    function automatic beat_t peek(input mc_addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return '0;
    endfunction

    always @(posedge clk) begin
        int lat;
        if (rst) begin
            cycle = 0;
            rsp_data_q.delete();
            rsp_due_q.delete();
        end else begin
            cycle = cycle + 1;
            if (mc_req_ld && !mc_req_stall) begin
                lat = 1 + int'($unsigned($random(seed)) % 6);
                rsp_due_q.push_back(cycle + lat);
                rsp_data_q.push_back(peek(mc_req_vadr));
            end
            if (mc_req_st && !mc_req_stall) begin
                mem[mc_req_vadr] = mc_req_wdata;
                st_count = st_count + 1;
            end
        end
    end

    // responses leave strictly in request order, at most one per cycle
    always @(negedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
            push_q  <= 1'b0;
            data_q  <= '0;
        end else begin
            stall_q <= (($random(seed) & 3) == 0);
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
                push_q <= 1'b1;
                data_q <= rsp_data_q.pop_front();
                void'(rsp_due_q.pop_front());
            end else begin
                push_q <= 1'b0;
            end
        end
    end

endmodule

// ==== tb/bps_tb.sv ====
`timescale 1ns/10ps

module bps_tb import bps_pkg::*; ();

    logic        clk;
    logic        rst;
    bps_op_t     opcode;
    logic [63:0] addr_base;
    logic        busy;
    logic        mc_req_ld;
    logic        mc_req_st;
    mc_addr_t    mc_req_vadr;
    beat_t       mc_req_wdata;
    logic        mc_req_stall;
    logic        mc_rsp_push;
    beat_t       mc_rsp_data;

    mc_addr_t    exp_ld_q [$];
    mc_addr_t    exp_st_addr_q [$];
    msg_word_t   exp_st_msg_q [$];
    data_word_t  got_word;
    msg_word_t   got_msg;
    logic        st_beat = 1'b0;

    bps_top i_bps_top (
        .clk          (clk),
        .rst          (rst),
        .opcode       (opcode),
        .addr_base    (addr_base),
        .busy         (busy),
        .mc_req_ld    (mc_req_ld),
        .mc_req_st    (mc_req_st),
        .mc_req_vadr  (mc_req_vadr),
        .mc_req_wdata (mc_req_wdata),
        .mc_req_stall (mc_req_stall),
        .mc_rsp_push  (mc_rsp_push),
        .mc_rsp_data  (mc_rsp_data)
    );

    bps_mem_model i_mem (
        .clk          (clk),
        .rst          (rst),
        .mc_req_ld    (mc_req_ld),
        .mc_req_st    (mc_req_st),
        .mc_req_vadr  (mc_req_vadr),
        .mc_req_wdata (mc_req_wdata),
        .mc_req_stall (mc_req_stall),
        .mc_rsp_push  (mc_rsp_push),
        .mc_rsp_data  (mc_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input mc_addr_t got, input mc_addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s address %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_msg(input msg_word_t got, input msg_word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s %h, expected %h", $time, what, got, exp));
        end
    endtask

    // distance of each label from the cheapest one, clipped at the top of the message range
    function automatic msg_word_t ref_msg(input data_word_t cost);
        int        min_cost;
        int        diff;
        msg_word_t m;
        min_cost = int'(cost.lanes[0]);
        for (int l = 1; l < LABELS; l++) begin
            if (int'(cost.lanes[l]) < min_cost) begin
                min_cost = int'(cost.lanes[l]);
            end
        end
        for (int l = 0; l < LABELS; l++) begin
            diff = int'(cost.lanes[l]) - min_cost;
            m[l] = (diff > MSG_MAX) ? msg_t'(MSG_MAX) : msg_t'(diff);
        end
        return m;
    endfunction

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            abort_run($sformatf("timed out after %0d cycles waiting for %s", limit, what));
        end
    endtask

    task automatic run_op(input bps_op_t op, input int limit);
        opcode = op;
        wait_busy(1'b1, 4, $sformatf("busy to rise after opcode %s", op.name()));
        opcode = OP_IDLE;
        wait_busy(1'b0, limit, $sformatf("opcode %s to finish", op.name()));
    endtask

    task automatic run_field(input logic [63:0] base);
        mc_addr_t   cost_base;
        mc_addr_t   store_base;
        data_word_t cost;
        int         st_before;
        cost_base  = base[47:0] + mc_addr_t'(DATA_OFFSET);
        store_base = cost_base + mc_addr_t'(WORD_BYTES * FIELD_CELLS);
        i_mem.fill_costs(cost_base);
        for (int i = 0; i < 2 * FIELD_CELLS; i++) begin
            exp_ld_q.push_back(cost_base + mc_addr_t'(i * BEAT_BYTES));
        end
        for (int c = 0; c < FIELD_WIDTH; c++) begin
            cost.beats[0] = i_mem.peek(cost_base + mc_addr_t'(c * WORD_BYTES));
            cost.beats[1] = i_mem.peek(cost_base + mc_addr_t'(c * WORD_BYTES + BEAT_BYTES));
            exp_st_msg_q.push_back(ref_msg(cost));
            exp_st_addr_q.push_back(store_base + mc_addr_t'(c * WORD_BYTES));
            exp_st_addr_q.push_back(store_base + mc_addr_t'(c * WORD_BYTES + BEAT_BYTES));
        end
        addr_base = base;
        run_op(OP_LOAD, 3000);
        if (exp_ld_q.size() != 0) begin
            abort_run("the load finished before every cost beat was requested");
        end
        run_op(OP_DOWN, 200);
        st_before = i_mem.st_count;
        run_op(OP_STORE_DOWN, 1000);
        if (exp_st_addr_q.size() != 0 || i_mem.st_count - st_before != 2 * FIELD_WIDTH) begin
            abort_run("the store finished with a wrong number of store requests");
        end
    endtask

    // every accepted request is compared on the clock edge that takes it
    always @(posedge clk) begin
        if (!rst) begin
            if (mc_req_ld && !mc_req_stall) begin
                if (exp_ld_q.size() == 0) begin
                    abort_run("a load request was issued that was not expected");
                end else begin
                    check_addr(mc_req_vadr, exp_ld_q.pop_front(), "load");
                end
            end
            if (mc_req_st && !mc_req_stall) begin
                if (exp_st_addr_q.size() == 0) begin
                    abort_run("a store request was issued that was not expected");
                end else begin
                    check_addr(mc_req_vadr, exp_st_addr_q.pop_front(), "store");
                    got_word.beats[st_beat] = mc_req_wdata;
                    if (st_beat) begin
                        for (int l = 0; l < LABELS; l++) begin
                            got_msg[l] = got_word.lanes[l][MSG_WIDTH-1:0];
                            check_bit(|got_word.lanes[l][COST_WIDTH-1:MSG_WIDTH], 1'b0,
                                      "upper bits of a stored message byte");
                        end
                        check_msg(got_msg, exp_st_msg_q.pop_front(), "stored message");
                    end
                    st_beat = !st_beat;
                end
            end
        end
    end

    initial begin
        rst       = 1'b1;
        opcode    = OP_IDLE;
        addr_base = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(mc_req_ld, 1'b0, "mc_req_ld after reset");
        check_bit(mc_req_st, 1'b0, "mc_req_st after reset");
        run_field(64'h0000_0000_0000_1000);
        run_field(64'h0000_0012_3456_7808);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
